/* rom.hex */
// 64 boot words b00700nn, then 8 vector words ec7000nn
// nn is the word index in the image
b0070000 b0070001 b0070002 b0070003 b0070004 b0070005 b0070006 b0070007
b0070008 b0070009 b007000a b007000b b007000c b007000d b007000e b007000f
b0070010 b0070011 b0070012 b0070013 b0070014 b0070015 b0070016 b0070017
b0070018 b0070019 b007001a b007001b b007001c b007001d b007001e b007001f
b0070020 b0070021 b0070022 b0070023 b0070024 b0070025 b0070026 b0070027
b0070028 b0070029 b007002a b007002b b007002c b007002d b007002e b007002f
b0070030 b0070031 b0070032 b0070033 b0070034 b0070035 b0070036 b0070037
b0070038 b0070039 b007003a b007003b b007003c b007003d b007003e b007003f
ec700040 ec700041 ec700042 ec700043 ec700044 ec700045 ec700046 ec700047

/* sim.f */
hdl/soc_pkg.sv
hdl/addr_decoder.sv
hdl/onchip_rom.sv
hdl/io_regs.sv
hdl/shared_ram.sv
hdl/resp_mux.sv
hdl/bus_fabric.sv
bench/tb_bus_fabric.sv

/* Makefile */
TOP = tb_bus_fabric

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Result: PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module bus_fabric

clean:
	rm -rf obj_dir sim.log

/* bench/tb_bus_fabric.sv */
`timescale 1ns/1ns

module tb_bus_fabric;

  import soc_pkg::*;

  // 14 rom, 24 ram, 10 shared, 5 io, 3 irq and 2 fault transfers
  localparam int XFERS = 58;
  localparam int LIMIT = 20 * XFERS;

  logic             sysclock;
  logic             rst_n;
  bus_req_t         cpu_req;
  bus_req_t         vid_req;
  logic [15:0]      sw_i;
  logic             key_i;
  bus_rsp_t         cpu_rsp;
  bus_rsp_t         vid_rsp;
  logic [15:0]      led;
  logic [IRQ_W:0]   irq_level;
  logic             fault;

  logic [31:0]      rom_img [IMAGE_WORDS];
  logic [31:0]      shadow [SSRAM_WORDS];
  // index 0 is the CPU, index 1 the video master
  logic [31:0]      got_dat [2];
  logic [31:0]      exp_dat [2];
  int               got_lat [2];
  int               exp_lat [2];
  logic             chk [2];
  logic             chk_dat [2];
  time              ack_t [2];
  logic             exp_fault;
  logic             irq_chk;
  logic [IRQ_W:0]   irq_exp;
  logic             led_chk;
  logic [15:0]      led_exp;
  logic             rnd_chk;
  logic             win_vid;
  logic             exp_win_vid;
  logic             last_vid;
  int               err_cnt;
  int               chk_cnt;
  int               cycles;

  bus_fabric bus_fabric_i (
    .sysclock    (sysclock),
    .rst_n       (rst_n),
    .cpu_req_i   (cpu_req),
    .vid_req_i   (vid_req),
    .sw_i        (sw_i),
    .key_i       (key_i),
    .cpu_rsp_o   (cpu_rsp),
    .vid_rsp_o   (vid_rsp),
    .led_o       (led),
    .irq_level_o (irq_level),
    .fault_o     (fault)
  );

  initial begin
    sysclock = 1'b0;
    forever #10 sysclock = ~sysclock;
  end

  always @(posedge sysclock) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("run stopped, test did not finish within %0d cycles", LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  for (genvar m = 0; m < 2; m++) begin : g_master
    a_dat : assert property (@(posedge sysclock) chk[m] && chk_dat[m] |->
      got_dat[m] == exp_dat[m])
      else begin
        err_cnt++;
        $display("ERROR %0t %s exp %h got %h", $time,
                 m == 0 ? "cpu_rsp_o.dat" : "vid_rsp_o.dat", exp_dat[m], got_dat[m]);
      end
    a_lat : assert property (@(posedge sysclock) chk[m] && exp_lat[m] != 0 |->
      got_lat[m] == exp_lat[m])
      else begin
        err_cnt++;
        $display("ERROR %0t %s latency exp %0d got %0d", $time,
                 m == 0 ? "cpu_rsp_o.ack" : "vid_rsp_o.ack", exp_lat[m], got_lat[m]);
      end
  end

  a_cpu_ack_req : assert property (@(posedge sysclock) disable iff (!rst_n)
    cpu_rsp.ack |-> cpu_req.cyc)
    else begin
      err_cnt++;
      $display("at %0t the CPU got an acknowledge without a request", $time);
    end

  a_vid_ack_req : assert property (@(posedge sysclock) disable iff (!rst_n)
    vid_rsp.ack |-> vid_req.cyc)
    else begin
      err_cnt++;
      $display("at %0t the video master got an acknowledge without a request", $time);
    end

  a_fault : assert property (@(posedge sysclock) disable iff (!rst_n)
    cpu_req.cyc |-> fault == exp_fault)
    else begin
      err_cnt++;
      $display("ERROR %0t fault_o exp %0b got %0b", $time, exp_fault, fault);
    end

  a_fault_irq : assert property (@(posedge sysclock) disable iff (!rst_n)
    fault |-> irq_level == '0)
    else begin
      err_cnt++;
      $display("ERROR %0t irq_level_o exp 0 got %0d", $time, irq_level);
    end

  a_irq : assert property (@(posedge sysclock) irq_chk |-> irq_level == irq_exp)
    else begin
      err_cnt++;
      $display("ERROR %0t irq_level_o exp %b got %b", $time, irq_exp, irq_level);
    end

  a_led : assert property (@(posedge sysclock) led_chk |-> led == led_exp)
    else begin
      err_cnt++;
      $display("ERROR %0t led_o exp %h got %h", $time, led_exp, led);
    end

  a_winner : assert property (@(posedge sysclock) rnd_chk |-> win_vid == exp_win_vid)
    else begin
      err_cnt++;
      $display("ERROR %0t ram winner exp vid=%0b got vid=%0b", $time, exp_win_vid, win_vid);
    end

  a_reset : assert property (@(posedge sysclock) $rose(rst_n) |->
    led == '0 && irq_level == '0 && !cpu_rsp.ack && !vid_rsp.ack)
    else begin
      err_cnt++;
      $display("at %0t outputs were not cleared by reset", $time);
    end

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0] sel);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // one transfer from request to dropped cyc with the result captured at a negedge
  task automatic xfer(input int m, input logic [31:0] adr, input logic [31:0] dat,
                      input logic [3:0] sel, input logic we, input logic dchk,
                      input logic [31:0] edat, input int elat);
    bus_req_t req;
    logic     ack;
    int       n;
    req = '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1};
    n = 0;
    @(posedge sysclock);
    if (m == 0) begin
      cpu_req <= req;
    end else begin
      vid_req <= req;
    end
    do begin
      @(posedge sysclock);
      n++;
      @(negedge sysclock);
      ack = (m == 0) ? cpu_rsp.ack : vid_rsp.ack;
    end while (!ack);
    got_dat[m] = (m == 0) ? cpu_rsp.dat : vid_rsp.dat;
    got_lat[m] = n;
    exp_dat[m] = edat;
    exp_lat[m] = elat;
    chk_dat[m] = dchk;
    ack_t[m]   = $time;
    chk[m]     = 1'b1;
    chk_cnt++;
    @(posedge sysclock);
    if (m == 0) begin
      cpu_req.cyc <= 1'b0;
    end else begin
      vid_req.cyc <= 1'b0;
    end
    @(negedge sysclock);
    chk[m] = 1'b0;
  endtask

  task automatic ram_wr(input int m, input int idx, input logic [31:0] dat,
                        input logic [3:0] sel, input int elat);
    xfer(m, SSRAM_BASE | 32'(idx << 2), dat, sel, 1'b1, 1'b0, '0, elat);
    shadow[idx] = merge_bytes(shadow[idx], dat, sel);
  endtask

  // reads go through an alias of the word
  task automatic ram_rd(input int m, input int idx, input int elat);
    xfer(m, SSRAM_BASE | 32'h0020_0000 | 32'(idx << 2), '0, 4'hf, 1'b0, 1'b1,
         shadow[idx], elat);
  endtask

  task automatic check_irq(input logic [IRQ_W:0] exp);
    @(negedge sysclock);
    irq_exp = exp;
    irq_chk = 1'b1;
    chk_cnt++;
    @(negedge sysclock);
    irq_chk = 1'b0;
  endtask

  task automatic check_led(input logic [15:0] exp);
    @(negedge sysclock);
    led_exp = exp;
    led_chk = 1'b1;
    chk_cnt++;
    @(negedge sysclock);
    led_chk = 1'b0;
  endtask

  initial begin
    int idx;
    int ia;
    int ib;
    void'($urandom(64989));
    $readmemh("rom.hex", rom_img);
    cpu_req   = '0;
    vid_req   = '0;
    sw_i      = '0;
    key_i     = 1'b0;
    rst_n     = 1'b0;
    exp_fault = 1'b0;
    irq_chk   = 1'b0;
    irq_exp   = '0;
    led_chk   = 1'b0;
    led_exp   = '0;
    rnd_chk   = 1'b0;
    chk[0]    = 1'b0;
    chk[1]    = 1'b0;
    last_vid  = 1'b0;
    err_cnt   = 0;
    chk_cnt   = 0;
    cycles    = 0;
    repeat (5) @(posedge sysclock);
    rst_n <= 1'b1;

    // boot rom with aliases, then the vector window
    for (int i = 0; i < 6; i++) begin
      idx = $urandom_range(0, ROM_WORDS - 1);
      xfer(0, ROM_BASE + 32'(i * 32'h1000) + 32'(idx << 2), '0, 4'hf, 1'b0, 1'b1,
           rom_img[idx], 2);
    end
    for (int k = 0; k < VECT_WORDS; k++) begin
      xfer(0, VECT_BASE + 32'(k << 2), '0, 4'hf, 1'b0, 1'b1, rom_img[ROM_WORDS + k], 2);
    end

    // cpu alone on the ram
    for (int i = 0; i < 8; i++) begin
      idx = $urandom_range(0, 511);
      ram_wr(0, idx, $urandom, 4'hf, 2);
      ram_wr(0, idx, $urandom, 4'($urandom_range(1, 15)), 2);
      ram_rd(0, idx, 2);
    end

    // both masters at once for writes and then reads
    ia = 0;
    ib = 0;
    for (int r = 0; r < 4; r++) begin
      if (r % 2 == 0) begin
        ia = $urandom_range(0, 511);
        ib = $urandom_range(512, SSRAM_WORDS - 1);
      end else begin
        // a lone video read makes the CPU the next tie winner
        ram_rd(1, ib, 2);
        last_vid = 1'b1;
      end
      exp_win_vid = !last_vid;
      if (r % 2 == 0) begin
        fork
          ram_wr(0, ia, $urandom, 4'hf, 0);
          ram_wr(1, ib, $urandom, 4'hf, 0);
        join
      end else begin
        fork
          ram_rd(0, ia, 0);
          ram_rd(1, ib, 0);
        join
      end
      win_vid  = ack_t[1] < ack_t[0];
      last_vid = !exp_win_vid;
      rnd_chk  = 1'b1;
      chk_cnt++;
      @(negedge sysclock);
      rnd_chk = 1'b0;
    end

    // led under byte selects, switch readback
    xfer(0, IO_BASE + 32'(IO_LED), 32'h0000_1234, 4'h3, 1'b1, 1'b0, '0, 1);
    xfer(0, IO_BASE + 32'(IO_LED), '0, 4'hf, 1'b0, 1'b1, 32'h0000_1234, 1);
    xfer(0, IO_BASE + 32'(IO_LED), 32'hffff_abcd, 4'h2, 1'b1, 1'b0, '0, 1);
    xfer(0, IO_BASE + 32'(IO_LED), '0, 4'hf, 1'b0, 1'b1, 32'h0000_ab34, 1);
    check_led(16'hab34);
    @(posedge sysclock);
    sw_i <= 16'h5a5a;
    repeat (3) @(posedge sysclock);
    xfer(0, IO_BASE + 32'(IO_SW), '0, 4'hf, 1'b0, 1'b1, 32'h0000_5a5a, 1);

    // switch interrupt, enable and clear
    xfer(0, IO_BASE + 32'(IO_ISR), 32'h3, 4'h1, 1'b1, 1'b0, '0, 1);
    xfer(0, IO_BASE + 32'(IO_IER), 32'h1, 4'h1, 1'b1, 1'b0, '0, 1);
    @(posedge sysclock);
    sw_i <= 16'h5a5b;
    repeat (5) @(posedge sysclock);
    check_irq(3'b101);
    xfer(0, IO_BASE + 32'(IO_ISR), 32'h1, 4'h1, 1'b1, 1'b0, '0, 1);
    repeat (2) @(posedge sysclock);
    check_irq(3'b000);

    // pending interrupt stays masked during faults
    @(posedge sysclock);
    sw_i <= 16'h0a5b;
    repeat (5) @(posedge sysclock);
    check_irq(3'b101);
    exp_fault = 1'b1;
    xfer(0, 32'h1000_0000, '0, 4'hf, 1'b0, 1'b1, '0, 1);
    xfer(0, ROM_BASE + 32'h8, 32'hdead_beef, 4'hf, 1'b1, 1'b1, '0, 1);
    exp_fault = 1'b0;

    repeat (2) @(posedge sysclock);
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* hdl/bus_fabric.sv */
`timescale 1ns/1ns

module bus_fabric (
  input  logic                    sysclock,
  input  logic                    rst_n,
  input  soc_pkg::bus_req_t       cpu_req_i,
  input  soc_pkg::bus_req_t       vid_req_i,
  input  logic [15:0]             sw_i,
  input  logic                    key_i,
  output soc_pkg::bus_rsp_t       cpu_rsp_o,
  output soc_pkg::bus_rsp_t       vid_rsp_o,
  output logic [15:0]             led_o,
  output logic [soc_pkg::IRQ_W:0] irq_level_o,
  output logic                    fault_o
);

  import soc_pkg::*;

  chip_sel_e        cs;
  bus_rsp_t         rom_rsp;
  bus_rsp_t         vect_rsp;
  bus_rsp_t         io_rsp;
  bus_rsp_t         ram_rsp;
  logic [IRQ_W-1:0] irq_pend;

  // per slave selects
  wire rom_sel   = (cs == CS_ROM);
  wire vect_sel  = (cs == CS_VECT);
  wire io_sel    = (cs == CS_IO);
  wire ssram_sel = (cs == CS_SSRAM);

  addr_decoder addr_decoder_i (
    .cpu_req_i (cpu_req_i),
    .cs_o      (cs),
    .fault_o   (fault_o)
  );

  onchip_rom onchip_rom_i (
    .sysclock   (sysclock),
    .rst_n      (rst_n),
    .cpu_req_i  (cpu_req_i),
    .rom_sel_i  (rom_sel),
    .vect_sel_i (vect_sel),
    .rom_rsp_o  (rom_rsp),
    .vect_rsp_o (vect_rsp)
  );

  io_regs io_regs_i (
    .sysclock   (sysclock),
    .rst_n      (rst_n),
    .cpu_req_i  (cpu_req_i),
    .io_sel_i   (io_sel),
    .sw_i       (sw_i),
    .key_i      (key_i),
    .led_o      (led_o),
    .io_rsp_o   (io_rsp),
    .irq_pend_o (irq_pend)
  );

  shared_ram shared_ram_i (
    .sysclock  (sysclock),
    .rst_n     (rst_n),
    .cpu_req_i (cpu_req_i),
    .cpu_sel_i (ssram_sel),
    .vid_req_i (vid_req_i),
    .cpu_rsp_o (ram_rsp),
    .vid_rsp_o (vid_rsp_o)
  );

  resp_mux resp_mux_i (
    .sysclock    (sysclock),
    .rst_n       (rst_n),
    .cpu_req_i   (cpu_req_i),
    .cs_i        (cs),
    .fault_i     (fault_o),
    .rom_rsp_i   (rom_rsp),
    .vect_rsp_i  (vect_rsp),
    .io_rsp_i    (io_rsp),
    .ram_rsp_i   (ram_rsp),
    .irq_pend_i  (irq_pend),
    .cpu_rsp_o   (cpu_rsp_o),
    .irq_level_o (irq_level_o)
  );

endmodule

/* hdl/resp_mux.sv */
`timescale 1ns/1ns

module resp_mux (
  input  logic                      sysclock,
  input  logic                      rst_n,
  input  soc_pkg::bus_req_t         cpu_req_i,
  input  soc_pkg::chip_sel_e        cs_i,
  input  logic                      fault_i,
  input  soc_pkg::bus_rsp_t         rom_rsp_i,
  input  soc_pkg::bus_rsp_t         vect_rsp_i,
  input  soc_pkg::bus_rsp_t         io_rsp_i,
  input  soc_pkg::bus_rsp_t         ram_rsp_i,
  input  logic [soc_pkg::IRQ_W-1:0] irq_pend_i,
  output soc_pkg::bus_rsp_t         cpu_rsp_o,
  output logic [soc_pkg::IRQ_W:0]   irq_level_o
);

  import soc_pkg::*;

  logic     none_ack;
  bus_rsp_t sel_rsp;

  // unmapped or refused access, one cycle pulse
  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      none_ack <= 1'b0;
    end else begin
      none_ack <= cpu_req_i.cyc && cs_i == CS_NONE && !none_ack;
    end
  end

  always_comb begin
    case (cs_i)
      CS_VECT:  sel_rsp = vect_rsp_i;
      CS_ROM:   sel_rsp = rom_rsp_i;
      CS_IO:    sel_rsp = io_rsp_i;
      CS_SSRAM: sel_rsp = ram_rsp_i;
      default:  sel_rsp = '{dat: '0, ack: none_ack};
    endcase
  end

  // no ack leaks out once the CPU has closed its cycle
  assign cpu_rsp_o = '{dat: sel_rsp.dat, ack: sel_rsp.ack && cpu_req_i.cyc};

  // a fault masks the io interrupts
  always_comb begin
    if (fault_i) begin
      irq_level_o = '0;
    end else if (|irq_pend_i) begin
      irq_level_o = {1'b1, irq_pend_i};
    end else begin
      irq_level_o = '0;
    end
  end

endmodule

/* hdl/shared_ram.sv */
`timescale 1ns/1ns

module shared_ram (
  input  logic              sysclock,
  input  logic              rst_n,
  input  soc_pkg::bus_req_t cpu_req_i,
  input  logic              cpu_sel_i,
  input  soc_pkg::bus_req_t vid_req_i,
  output soc_pkg::bus_rsp_t cpu_rsp_o,
  output soc_pkg::bus_rsp_t vid_rsp_o
);

  import soc_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    GRANT,
    ACK
  } ram_state_e;

  ram_state_e          state;
  logic                cpu_rq;
  logic                vid_rq;
  logic                pick_vid;
  logic                gnt_cpu;
  logic                gnt_vid;
  logic                gnt_cyc;
  logic                last_vid;
  logic                ack_q;
  bus_req_t            gnt_req;
  logic [SSRAM_AW-1:0] word;
  logic [31:0]         mem [SSRAM_WORDS];
  logic [31:0]         rd_dat;

  assign cpu_rq = cpu_sel_i && cpu_req_i.cyc;
  assign vid_rq = vid_req_i.cyc;

  // on a tie the master not served last goes first
  assign pick_vid = vid_rq && (!cpu_rq || !last_vid);

  assign gnt_req = gnt_vid ? vid_req_i : cpu_req_i;
  assign gnt_cyc = gnt_vid ? vid_rq : cpu_rq;
  assign word    = gnt_req.adr[SSRAM_AW+1:2];

  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      gnt_cpu  <= 1'b0;
      gnt_vid  <= 1'b0;
      last_vid <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (cpu_rq || vid_rq) begin
            gnt_vid  <= pick_vid;
            gnt_cpu  <= !pick_vid;
            last_vid <= pick_vid;
            state    <= GRANT;
          end
        end
        GRANT: begin
          ack_q <= 1'b1;
          state <= ACK;
        end
        ACK: begin
          ack_q <= 1'b0;
          // owner keeps the grant until its cycle ends
          if (!gnt_cyc) begin
            gnt_cpu <= 1'b0;
            gnt_vid <= 1'b0;
            state   <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // access happens once, on the grant to ack edge
  always_ff @(posedge sysclock) begin
    if (state == GRANT) begin
      rd_dat <= mem[word];
      if (gnt_req.we) begin
        for (int b = 0; b < 4; b++) begin
          if (gnt_req.sel[b]) begin
            mem[word][8*b +: 8] <= gnt_req.dat[8*b +: 8];
          end
        end
      end
    end
  end

  assign cpu_rsp_o = '{dat: rd_dat, ack: ack_q && gnt_cpu};
  assign vid_rsp_o = '{dat: rd_dat, ack: ack_q && gnt_vid};

  a_one_grant : assert property (@(posedge sysclock) disable iff (!rst_n)
    !(gnt_cpu && gnt_vid));

  // ack goes to a master that still requests and already held the grant
  a_cpu_ack_owner : assert property (@(posedge sysclock) disable iff (!rst_n)
    cpu_rsp_o.ack |-> cpu_rq && $past(gnt_cpu));

  a_vid_ack_owner : assert property (@(posedge sysclock) disable iff (!rst_n)
    vid_rsp_o.ack |-> vid_rq && $past(gnt_vid));

endmodule

/* hdl/io_regs.sv */
`timescale 1ns/1ns

module io_regs (
  input  logic                      sysclock,
  input  logic                      rst_n,
  input  soc_pkg::bus_req_t         cpu_req_i,
  input  logic                      io_sel_i,
  input  logic [15:0]               sw_i,
  input  logic                      key_i,
  output logic [15:0]               led_o,
  output soc_pkg::bus_rsp_t         io_rsp_o,
  output logic [soc_pkg::IRQ_W-1:0] irq_pend_o
);

  import soc_pkg::*;

  logic [15:0]      sw_s1;
  logic [15:0]      sw_s2;
  logic [15:0]      sw_q;
  // two sync stages plus one history stage
  logic [2:0]       key_s;
  logic [IRQ_W-1:0] isr;
  logic [IRQ_W-1:0] ier;
  logic [IRQ_W-1:0] isr_set;
  logic [IRQ_W-1:0] isr_clr;
  logic [10:0]      reg_off;
  logic             access;
  logic             wr_en;
  logic             ack_q;
  logic [31:0]      rd_nxt;
  logic [31:0]      rd_dat;

  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      sw_s1 <= '0;
      sw_s2 <= '0;
      sw_q  <= '0;
      key_s <= '0;
    end else begin
      sw_s1 <= sw_i;
      sw_s2 <= sw_s1;
      sw_q  <= sw_s2;
      key_s <= {key_s[1:0], key_i};
    end
  end

  // bit 1 on key press, bit 0 on any switch movement
  assign isr_set = {key_s[1] & ~key_s[2], |(sw_s2 ^ sw_q)};

  // first cycle of a request only, ack follows one cycle later
  assign access  = io_sel_i && cpu_req_i.cyc && !ack_q;
  assign wr_en   = access && cpu_req_i.we;
  assign reg_off = {cpu_req_i.adr[10:2], 2'b00};

  assign isr_clr = (wr_en && reg_off == IO_ISR && cpu_req_i.sel[0]) ?
                   cpu_req_i.dat[IRQ_W-1:0] : '0;

  always_comb begin
    case (reg_off)
      IO_LED:  rd_nxt = {16'h0000, led_o};
      IO_SW:   rd_nxt = {16'h0000, sw_s2};
      IO_ISR:  rd_nxt = 32'(isr);
      IO_IER:  rd_nxt = 32'(ier);
      default: rd_nxt = '0;
    endcase
  end

  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      led_o <= '0;
      isr   <= '0;
      ier   <= '0;
    end else begin
      ack_q <= access;
      // a new event wins over a clear in the same cycle
      isr <= isr_set | (isr & ~isr_clr);
      if (wr_en && reg_off == IO_LED) begin
        if (cpu_req_i.sel[0]) begin
          led_o[7:0] <= cpu_req_i.dat[7:0];
        end
        if (cpu_req_i.sel[1]) begin
          led_o[15:8] <= cpu_req_i.dat[15:8];
        end
      end
      if (wr_en && reg_off == IO_IER && cpu_req_i.sel[0]) begin
        ier <= cpu_req_i.dat[IRQ_W-1:0];
      end
    end
  end

  always_ff @(posedge sysclock) begin
    if (access) begin
      rd_dat <= rd_nxt;
    end
  end

  assign io_rsp_o   = '{dat: rd_dat, ack: ack_q};
  assign irq_pend_o = isr & ier;

endmodule

/* hdl/onchip_rom.sv */
`timescale 1ns/1ns

module onchip_rom (
  input  logic              sysclock,
  input  logic              rst_n,
  input  soc_pkg::bus_req_t cpu_req_i,
  input  logic              rom_sel_i,
  input  logic              vect_sel_i,
  output soc_pkg::bus_rsp_t rom_rsp_o,
  output soc_pkg::bus_rsp_t vect_rsp_o
);

  import soc_pkg::*;

  // boot image first, vector words right behind it
  logic [31:0] image [IMAGE_WORDS];

  // index 0 is the boot ROM, index 1 the vectors
  logic [IMAGE_AW-1:0] rd_idx [2];
  logic [1:0]          rd_sel;
  logic [31:0]         rd_dat [2];
  logic [1:0]          ack_sr [2];

  initial begin
    $readmemh(ROM_FILE, image);
  end

  // both windows alias on their low word bits
  assign rd_idx[0] = IMAGE_AW'(cpu_req_i.adr[ROM_AW+1:2]);
  assign rd_idx[1] = IMAGE_AW'(ROM_WORDS) + IMAGE_AW'(cpu_req_i.adr[VECT_AW+1:2]);

  assign rd_sel = {vect_sel_i, rom_sel_i} & {2{cpu_req_i.cyc}};

  for (genvar g = 0; g < 2; g++) begin : g_port

    always_ff @(posedge sysclock) begin
      if (rd_sel[g]) begin
        rd_dat[g] <= image[rd_idx[g]];
      end
    end

    // two stage ack, cleared as soon as the cycle ends
    always_ff @(posedge sysclock or negedge rst_n) begin
      if (!rst_n) begin
        ack_sr[g] <= 2'b00;
      end else if (!cpu_req_i.cyc) begin
        ack_sr[g] <= 2'b00;
      end else begin
        ack_sr[g] <= {ack_sr[g][0], rd_sel[g]};
      end
    end

    // ack only rises for a cycle that has been held since it was sampled
    a_ack_needs_cyc : assert property (@(posedge sysclock) disable iff (!rst_n)
      $rose(ack_sr[g][1]) |-> cpu_req_i.cyc && $past(cpu_req_i.cyc, 2));

  end

  assign rom_rsp_o  = '{dat: rd_dat[0], ack: ack_sr[0][1]};
  assign vect_rsp_o = '{dat: rd_dat[1], ack: ack_sr[1][1]};

endmodule

/* hdl/addr_decoder.sv */
`timescale 1ns/1ns

module addr_decoder (
  input  soc_pkg::bus_req_t  cpu_req_i,
  output soc_pkg::chip_sel_e cs_o,
  output logic               fault_o
);

  import soc_pkg::*;

  chip_sel_e window;
  logic      rom_write;

  // priority order, vectors sit at the top of the ROM range
  always_comb begin
    if (cpu_req_i.adr >= VECT_BASE) begin
      window = CS_VECT;
    end else if (cpu_req_i.adr >= ROM_BASE) begin
      window = CS_ROM;
    end else if ((cpu_req_i.adr & ~IO_MASK) == IO_BASE) begin
      window = CS_IO;
    end else if ((cpu_req_i.adr & ~SSRAM_MASK) == SSRAM_BASE) begin
      window = CS_SSRAM;
    end else begin
      window = CS_NONE;
    end
  end

  // both ROMs are read only
  assign rom_write = cpu_req_i.we && (window == CS_VECT || window == CS_ROM);

  // refused writes are completed by the response mux like unmapped space
  assign cs_o = rom_write ? CS_NONE : window;

  assign fault_o = cpu_req_i.cyc && (window == CS_NONE || rom_write);

endmodule

/* hdl/soc_pkg.sv */
package soc_pkg;

  // slave chip selects
  typedef enum logic [3:0] {
    CS_NONE  = 4'h0,
    CS_VECT  = 4'h1,
    CS_ROM   = 4'h2,
    CS_IO    = 4'h4,
    CS_SSRAM = 4'h6
  } chip_sel_e;

  // master request, same shape for CPU and video
  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic        we;
    logic        cyc;
  } bus_req_t;

  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
  } bus_rsp_t;

  // address map
  localparam logic [31:0] VECT_BASE   = 32'hffff_ffe0;
  localparam int          VECT_WORDS  = 8;
  localparam int          VECT_AW     = $clog2(VECT_WORDS);
  localparam logic [31:0] ROM_BASE    = 32'hfffe_0000;
  localparam int          ROM_WORDS   = 64;
  localparam int          ROM_AW      = $clog2(ROM_WORDS);
  localparam int          IMAGE_WORDS = ROM_WORDS + VECT_WORDS;
  localparam int          IMAGE_AW    = $clog2(IMAGE_WORDS);
  localparam logic [31:0] IO_BASE     = 32'h2000_0800;
  localparam logic [31:0] IO_MASK     = 32'h0000_07ff;
  localparam logic [31:0] SSRAM_BASE  = 32'hc000_0000;
  localparam logic [31:0] SSRAM_MASK  = 32'h003f_ffff;
  localparam int          SSRAM_WORDS = 1024;
  localparam int          SSRAM_AW    = $clog2(SSRAM_WORDS);

  // io register byte offsets inside the 2 KB window
  localparam logic [10:0] IO_LED = 11'h000;
  localparam logic [10:0] IO_SW  = 11'h004;
  localparam logic [10:0] IO_ISR = 11'h008;
  localparam logic [10:0] IO_IER = 11'h00c;

  localparam int IRQ_W = 2;

  localparam string ROM_FILE = "rom.hex";

endpackage
